// File: compile.f
src/ltc2195_pkg.sv
src/spi_master.sv
src/adc_init_sequencer.sv
src/enc_phase_stepper.sv
src/ltc2195_ctrl.sv
tests/tb_clock_gen.sv
tests/ltc2195_ctrl_checker.sv
tests/ltc2195_ctrl_tb.sv

// File: src/adc_init_sequencer.sv
//////////////////////////////////////////////////////////////////////
// ADC configuration sequencer
//   power-up wait, then the three init words over SPI
//   register writes from the 0x31 command prefix
//   request side of the SPI engine link
//////////////////////////////////////////////////////////////////////

module adc_init_sequencer #(
	parameter int RESET_WAIT = 255	// cycles before the first frame
) (
	input  logic                   clk_in,
	input  logic                   rst_in,
	input  logic                   cmd_trig_in,
	input  ltc2195_pkg::cmd_addr_t cmd_addr_in,
	input  ltc2195_pkg::cmd_data_t cmd_data_in,
	input  logic                   spi_ready,
	output logic                   spi_start,
	output ltc2195_pkg::spi_word_t spi_word
);
	import ltc2195_pkg::*;

	localparam int WAIT_W = (RESET_WAIT > 1) ? $clog2(RESET_WAIT + 1) : 1;
	localparam int IDX_W  = $clog2(INIT_LEN);

	typedef enum logic [1:0] {
		ST_WAIT,	// power-up countdown
		ST_INIT,	// init word loaded, waiting on ready
		ST_IDLE,	// accepting register writes
		ST_CMD		// command word loaded, waiting on ready
	} state_t;

	state_t            state;
	logic [WAIT_W-1:0] wait_cnt;
	logic [IDX_W-1:0]  init_idx;	// current INIT_WORDS entry
	logic              wait_done;
	logic              cmd_hit;
	logic              init_last;

	assign wait_done = (state == ST_WAIT) && (wait_cnt <= WAIT_W'(1));
	assign cmd_hit   = (state == ST_IDLE) && cmd_trig_in &&
	                   (cmd_addr_in[15:8] == CMD_SPI_WRITE);
	assign init_last = (init_idx == IDX_W'(INIT_LEN - 1));

	// request fires only while the engine says ready
	assign spi_start = ((state == ST_INIT) || (state == ST_CMD)) && spi_ready;

	//////////////////////////////////////////////////////////////////////
	// control FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state    <= ST_WAIT;
			wait_cnt <= WAIT_W'(RESET_WAIT);
			init_idx <= '0;
		end else begin
			case (state)
				ST_WAIT: begin
					wait_cnt <= wait_cnt - 1'b1;
					if (wait_done)
						state <= ST_INIT;	// word 0 loaded alongside
				end

				ST_INIT: begin
					if (spi_start) begin
						if (init_last)
							state <= ST_IDLE;
						else
							init_idx <= init_idx + 1'b1;
					end
				end

				ST_IDLE: begin
					if (cmd_hit)
						state <= ST_CMD;	// other prefixes fall through
				end

				ST_CMD: begin
					if (spi_start)
						state <= ST_IDLE;
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// outgoing word, held until the engine takes it

	always_ff @(posedge clk_in) begin
		if (wait_done) begin
			spi_word <= INIT_WORDS[0];
		end else if ((state == ST_INIT) && spi_start && !init_last) begin
			spi_word <= INIT_WORDS[init_idx + 1'b1];	// next table entry
		end else if (cmd_hit) begin
			spi_word <= '{
				rw:   SPI_WR,
				addr: cmd_addr_in[6:0],	// register from low address bits
				data: cmd_data_in[7:0]
			};
		end
	end

endmodule

// File: src/enc_phase_stepper.sv
//////////////////////////////////////////////////////////////////////
// encode clock phase stepper
//   phase value and target, target set by the 0x32 prefix
//   one-step handshake on the clock manager phase-shift port
//   clamp to the 9-bit phase range
//////////////////////////////////////////////////////////////////////

module enc_phase_stepper #(
	parameter ltc2195_pkg::ps_value_t PS_DEFAULT_TARGET = 9'h17C
) (
	input  logic                   clk_in,
	input  logic                   rst_in,
	input  logic                   cmd_trig_in,
	input  ltc2195_pkg::cmd_addr_t cmd_addr_in,
	input  ltc2195_pkg::cmd_data_t cmd_data_in,
	input  logic                   ps_done_in,
	input  logic                   ps_locked_in,
	output logic                   ps_en_out,
	output logic                   ps_inc_out,
	output logic                   ps_clk_out,
	output logic                   ps_busy_out
);
	import ltc2195_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,		// at target, taking commands
		ST_DECIDE,		// pick up, down or stop
		ST_ENABLE,		// raise enable with direction
		ST_CLOCK,		// single psclk rise under enable
		ST_DONE_WAIT,	// keep psclk running until done
		ST_COUNT		// commit the step
	} state_t;

	state_t    state;
	ps_value_t ps_value;	// where the clock manager sits now
	ps_value_t ps_target;
	logic      cmd_hit;
	logic      can_up;
	logic      can_down;

	assign cmd_hit = (state == ST_IDLE) && cmd_trig_in &&
	                 (cmd_addr_in[15:8] == CMD_PHASE_SET);

	// direction, held back at the range ends
	assign can_up   = (ps_target > ps_value) && (ps_value < PS_MAX);
	assign can_down = (ps_target < ps_value) && (ps_value > PS_MIN);

	assign ps_busy_out = (state != ST_IDLE);

	//////////////////////////////////////////////////////////////////////
	// step FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state      <= ST_DECIDE;	// head for the default target at once
			ps_value   <= PS_CENTER;
			ps_target  <= PS_DEFAULT_TARGET;
			ps_en_out  <= 1'b0;
			ps_inc_out <= 1'b0;
			ps_clk_out <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					ps_en_out  <= 1'b0;
					ps_clk_out <= 1'b0;
					if (cmd_hit) begin
						ps_target <= cmd_data_in[8:0];
						state     <= ST_DECIDE;
					end
				end

				ST_DECIDE: begin
					// no step while the clock manager is out of lock
					if (ps_locked_in) begin
						if (can_up) begin
							ps_inc_out <= 1'b1;
							state      <= ST_ENABLE;
						end else if (can_down) begin
							ps_inc_out <= 1'b0;
							state      <= ST_ENABLE;
						end else begin
							state <= ST_IDLE;	// reached target or a limit
						end
					end
				end

				ST_ENABLE: begin
					ps_en_out <= 1'b1;
					state     <= ST_CLOCK;
				end

				ST_CLOCK: begin
					ps_clk_out <= 1'b1;	// the one edge that sees enable
					state      <= ST_DONE_WAIT;
				end

				ST_DONE_WAIT: begin
					ps_en_out <= 1'b0;	// drops with the first psclk fall
					if (ps_done_in) begin
						ps_clk_out <= 1'b0;
						state      <= ST_COUNT;
					end else begin
						ps_clk_out <= ~ps_clk_out;
					end
				end

				ST_COUNT: begin
					if (ps_inc_out)
						ps_value <= ps_value + 1'b1;
					else
						ps_value <= ps_value - 1'b1;
					state <= ST_DECIDE;
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/ltc2195_ctrl.sv
//////////////////////////////////////////////////////////////////////
// LTC2195 control top level
//   SPI configuration path and encode phase stepper
//   plain command, SPI and phase-shift pins
//////////////////////////////////////////////////////////////////////

module ltc2195_ctrl #(
	parameter int                     SPI_CLK_DIV       = 5,		// 10 MHz sck from 100 MHz
	parameter int                     RESET_WAIT        = 255,
	parameter ltc2195_pkg::ps_value_t PS_DEFAULT_TARGET = 9'h17C	// centre plus 124
) (
	input  logic                   clk_in,
	input  logic                   rst_in,

	// command port
	input  logic                   cmd_trig_in,
	input  ltc2195_pkg::cmd_addr_t cmd_addr_in,
	input  ltc2195_pkg::cmd_data_t cmd_data_in,

	// ADC SPI
	output logic                   spi_scs_out,
	output logic                   spi_sck_out,
	output logic                   spi_sdo_out,

	// clock manager phase shift
	output logic                   ps_en_out,
	output logic                   ps_inc_out,
	output logic                   ps_clk_out,
	input  logic                   ps_done_in,
	input  logic                   ps_locked_in,
	output logic                   ps_busy_out
);
	import ltc2195_pkg::*;

	logic      spi_start;	// sequencer to engine request
	logic      spi_ready;
	spi_word_t spi_word;

	adc_init_sequencer #(
		.RESET_WAIT(RESET_WAIT)
	) u_seq (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.cmd_trig_in (cmd_trig_in),
		.cmd_addr_in (cmd_addr_in),
		.cmd_data_in (cmd_data_in),
		.spi_ready   (spi_ready),
		.spi_start   (spi_start),
		.spi_word    (spi_word)
	);

	spi_master #(
		.SPI_CLK_DIV(SPI_CLK_DIV)
	) u_spi (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.spi_start   (spi_start),
		.spi_word    (spi_word),
		.spi_ready   (spi_ready),
		.spi_scs_out (spi_scs_out),
		.spi_sck_out (spi_sck_out),
		.spi_sdo_out (spi_sdo_out)
	);

	enc_phase_stepper #(
		.PS_DEFAULT_TARGET(PS_DEFAULT_TARGET)
	) u_ps (
		.clk_in       (clk_in),
		.rst_in       (rst_in),
		.cmd_trig_in  (cmd_trig_in),
		.cmd_addr_in  (cmd_addr_in),
		.cmd_data_in  (cmd_data_in),
		.ps_done_in   (ps_done_in),
		.ps_locked_in (ps_locked_in),
		.ps_en_out    (ps_en_out),
		.ps_inc_out   (ps_inc_out),
		.ps_clk_out   (ps_clk_out),
		.ps_busy_out  (ps_busy_out)
	);

endmodule

// File: src/ltc2195_pkg.sv
//////////////////////////////////////////////////////////////////////
// LTC2195 control definitions
//   command port word types and function prefixes
//   SPI frame layout and ADC register addresses
//   power-up configuration table
//   encode clock phase-shift limits
//////////////////////////////////////////////////////////////////////

package ltc2195_pkg;

	// command port
	typedef logic [15:0] cmd_addr_t;	// upper byte picks the function
	typedef logic [15:0] cmd_data_t;

	localparam logic [7:0] CMD_SPI_WRITE = 8'h31;	// write one ADC register
	localparam logic [7:0] CMD_PHASE_SET = 8'h32;	// new encode phase target

	// SPI frame, sent MSB first
	typedef struct packed {
		logic       rw;		// high for a read
		logic [6:0] addr;	// ADC register
		logic [7:0] data;
	} spi_word_t;

	localparam logic SPI_WR = 1'b0;

	localparam logic [6:0] REG_RESET  = 7'h00;
	localparam logic [6:0] REG_FORMAT = 7'h01;
	localparam logic [6:0] REG_LANES  = 7'h02;

	// sent in order once the power-up wait expires
	localparam int INIT_LEN = 3;
	localparam spi_word_t INIT_WORDS [INIT_LEN] = '{
		'{rw: SPI_WR, addr: REG_RESET,  data: 8'h80},	// software reset
		'{rw: SPI_WR, addr: REG_FORMAT, data: 8'h20},	// two's complement out
		'{rw: SPI_WR, addr: REG_LANES,  data: 8'h00}	// two-lane output mode
	};

	// dynamic phase shift position
	typedef logic [8:0] ps_value_t;

	localparam ps_value_t PS_CENTER = 9'h100;	// position after reset
	localparam ps_value_t PS_MIN    = 9'h000;
	localparam ps_value_t PS_MAX    = 9'h1FF;

endpackage

// File: src/spi_master.sv
//////////////////////////////////////////////////////////////////////
// SPI write engine
//   one 16-bit word per start pulse, MSB first
//   sck idles low, data changes on the falling edge
//   chip select active low, ready back one cycle after it rises
//////////////////////////////////////////////////////////////////////

module spi_master #(
	parameter int SPI_CLK_DIV = 5	// clk_in cycles per sck half period
) (
	input  logic                   clk_in,
	input  logic                   rst_in,
	input  logic                   spi_start,
	input  ltc2195_pkg::spi_word_t spi_word,
	output logic                   spi_ready,
	output logic                   spi_scs_out,
	output logic                   spi_sck_out,
	output logic                   spi_sdo_out
);
	import ltc2195_pkg::*;

	localparam int WORD_W = $bits(spi_word_t);
	localparam int DIV_W  = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;
	localparam int BIT_W  = $clog2(WORD_W);

	typedef enum logic [1:0] {
		ST_IDLE,	// waiting for a request
		ST_SHIFT,	// clocking the word out
		ST_FINISH	// last falling edge done, release cs
	} state_t;

	state_t            state;
	logic [DIV_W-1:0]  div_cnt;	// position inside a half period
	logic [BIT_W-1:0]  bit_cnt;	// bits already sent
	logic [WORD_W-1:0] shift_q;
	logic              half_done;

	assign half_done   = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
	assign spi_sdo_out = shift_q[WORD_W-1];	// MSB always on the pin

	//////////////////////////////////////////////////////////////////////
	// frame FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state       <= ST_IDLE;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			shift_q     <= '0;
			spi_ready   <= 1'b1;
			spi_scs_out <= 1'b1;
			spi_sck_out <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					spi_ready <= 1'b1;	// one cycle after cs went high
					div_cnt   <= '0;
					bit_cnt   <= '0;
					if (spi_start && spi_ready) begin
						shift_q     <= spi_word;
						spi_scs_out <= 1'b0;	// frame opens next cycle
						spi_ready   <= 1'b0;
						state       <= ST_SHIFT;
					end
				end

				ST_SHIFT: begin
					if (half_done) begin
						div_cnt     <= '0;
						spi_sck_out <= ~spi_sck_out;
						// falling edge, move on to the next bit
						if (spi_sck_out) begin
							shift_q <= {shift_q[WORD_W-2:0], 1'b0};
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_W'(WORD_W - 1))
								state <= ST_FINISH;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end

				ST_FINISH: begin
					spi_scs_out <= 1'b1;	// sck already low
					state       <= ST_IDLE;
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: tests/ltc2195_cases.txt
# kind  address  data  expected (spi, init: frame word; phase, lock, boot: step count)
# init and boot lines describe power-up; lock holds the clock manager out of lock first
init   0000  0000  0080
init   0000  0000  0120
init   0000  0000  0200
boot   0000  017C  007C
spi    3105  00A7  05A7
phase  3200  0190  0014
spi    31FF  1234  7F34
phase  3200  0E05  018B
other  3300  0040  0000
phase  3200  0000  0005
lock   3200  01FF  01FF
phase  3200  01FF  0000
phase  3200  0123  00DC
spi    3102  0000  0200
other  0031  0000  0000

// File: tests/ltc2195_ctrl_checker.sv
//////////////////////////////////////////////////////////////////////
// LTC2195 control checker
//   SPI frame decode from the pins, compared with queued words
//   phase pulse count and direction, own copy of the phase value
//   lock, enable width and leftover expectation checks
//////////////////////////////////////////////////////////////////////

module ltc2195_ctrl_checker (
	input  logic scs,
	input  logic sck,
	input  logic sdo,
	input  logic ps_en,
	input  logic ps_inc,
	input  logic ps_clk,
	input  logic ps_locked,
	input  logic ps_busy,
	output int   frames_seen,
	output int   moves_seen,
	output int   check_cnt,
	output int   error_cnt
);
	timeunit 1ns;
	timeprecision 100ps;
	import ltc2195_pkg::*;

	spi_word_t   frame_q [$];	// expected frames, in order
	ps_value_t   move_tgt_q [$];
	int          move_cnt_q [$];
	ps_value_t   model_ps;	// where the clock manager should sit
	logic [15:0] shreg;
	int          bit_cnt;
	logic        in_frame;
	int          pulse_cnt;	// enable pulses in the current move
	logic        en_prev;

	initial begin
		frames_seen = 0;
		moves_seen  = 0;
		check_cnt   = 0;
		error_cnt   = 0;
		model_ps    = PS_CENTER;
		in_frame    = 1'b0;
		pulse_cnt   = 0;
		en_prev     = 1'b0;
	end

	task automatic push_frame(input spi_word_t word);
		frame_q.push_back(word);
	endtask

	task automatic push_move(input ps_value_t target, input int steps);
		move_tgt_q.push_back(target);
		move_cnt_q.push_back(steps);
	endtask

	// nothing in flight, nothing left over
	task automatic check_quiet();
		check_cnt++;
		if (pulse_cnt != 0) begin
			$display("Error ps_en_out pulses: got %h expected %h", pulse_cnt, 0);
			error_cnt++;
		end
		if (in_frame || frame_q.size() != 0 || move_tgt_q.size() != 0) begin
			$display("expected SPI frames or phase moves never completed");
			error_cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// SPI side

	always @(negedge scs) begin
		in_frame = 1'b1;
		bit_cnt  = 0;
		shreg    = '0;
	end

	always @(posedge sck) begin
		if (scs) begin
			$display("spi_sck_out rose while chip select was high");
			error_cnt++;
		end
		shreg = {shreg[14:0], sdo};	// sampled on the rising edge
		bit_cnt++;
	end

	always @(posedge scs) begin : frame_end
		spi_word_t exp_word;
		if (in_frame) begin
			in_frame = 1'b0;
			frames_seen++;
			check_cnt++;
			if (bit_cnt != 16) begin
				$display("SPI frame ended after %0d rising sck edges", bit_cnt);
				error_cnt++;
			end
			if (frame_q.size() == 0) begin
				$display("SPI frame %h appeared with none expected", shreg);
				error_cnt++;
			end else begin
				exp_word = frame_q.pop_front();
				if (shreg !== exp_word) begin
					$display("Error spi_sdo_out frame: got %h expected %h", shreg, exp_word);
					error_cnt++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// phase-shift side

	always @(posedge ps_clk) begin : pulse_watch
		logic exp_inc;
		if (ps_en) begin
			pulse_cnt++;
			if (en_prev) begin
				$display("ps_en_out stayed high over two ps_clk_out rising edges");
				error_cnt++;
			end
			if (!ps_locked) begin
				$display("enable pulse while the clock manager was out of lock");
				error_cnt++;
			end
			if (move_tgt_q.size() == 0) begin
				$display("enable pulse with no phase move expected");
				error_cnt++;
			end else begin
				exp_inc = (move_tgt_q[0] > model_ps);	// direction toward target
				check_cnt++;
				if (ps_inc !== exp_inc) begin
					$display("Error ps_inc_out: got %h expected %h", ps_inc, exp_inc);
					error_cnt++;
				end
			end
		end
		en_prev = ps_en;
	end

	always @(negedge ps_busy) begin : move_end
		ps_value_t tgt;
		int        steps;
		check_cnt++;
		if (move_tgt_q.size() == 0) begin
			$display("ps_busy_out fell with no phase move expected");
			error_cnt++;
		end else begin
			tgt   = move_tgt_q.pop_front();
			steps = move_cnt_q.pop_front();
			if (pulse_cnt != steps) begin
				$display("Error ps_en_out pulses: got %h expected %h", pulse_cnt, steps);
				error_cnt++;
			end
			model_ps = tgt;
		end
		moves_seen++;
		pulse_cnt = 0;
	end

endmodule

// File: tests/ltc2195_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// LTC2195 control testbench top
//   DUT, clock, checker and case-file reader
//   command driver and clock manager responder
//   cycle-count timeout
//////////////////////////////////////////////////////////////////////

module ltc2195_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ltc2195_pkg::*;

	localparam int STEP_CYCLES  = 16;	// worst single phase step
	localparam int CASE_CYCLES  = (int'(PS_MAX) + 1) * STEP_CYCLES + 400;
	localparam int LOCK_DELAY   = 40;	// clock manager start-up
	localparam int LOCK_HOLD    = 30;
	localparam int QUIET_CYCLES = 100;

	logic      clk_in;
	logic      rst_in;
	logic      cmd_trig_in;
	cmd_addr_t cmd_addr_in;
	cmd_data_t cmd_data_in;
	logic      spi_scs_out;
	logic      spi_sck_out;
	logic      spi_sdo_out;
	logic      ps_en_out;
	logic      ps_inc_out;
	logic      ps_clk_out;
	logic      ps_done_in;
	logic      ps_locked_in;
	logic      ps_busy_out;
	int        frames_seen;
	int        moves_seen;
	int        check_cnt;
	int        error_cnt;
	int        tb_err_cnt;
	int        cycle_cnt;
	int        cycle_limit;
	integer    seed = 32'h14b5;

	// case table from the file
	logic [63:0] case_kind [$];
	logic [15:0] case_addr [$];
	logic [15:0] case_data [$];
	logic [15:0] case_exp [$];

	tb_clock_gen clk_gen (.clk_in(clk_in), .rst_in(rst_in));

	ltc2195_ctrl #(
		.SPI_CLK_DIV (2),
		.RESET_WAIT  (20)
	) dut (
		.clk_in, .rst_in, .cmd_trig_in, .cmd_addr_in, .cmd_data_in,
		.spi_scs_out, .spi_sck_out, .spi_sdo_out,
		.ps_en_out, .ps_inc_out, .ps_clk_out, .ps_done_in, .ps_locked_in, .ps_busy_out
	);

	ltc2195_ctrl_checker chk (
		.scs(spi_scs_out), .sck(spi_sck_out), .sdo(spi_sdo_out),
		.ps_en(ps_en_out), .ps_inc(ps_inc_out), .ps_clk(ps_clk_out),
		.ps_locked(ps_locked_in), .ps_busy(ps_busy_out),
		.frames_seen, .moves_seen, .check_cnt, .error_cnt
	);

	//////////////////////////////////////////////////////////////////////
	// clock manager model, done after 1 to 8 psclk edges

	always begin : ps_responder
		int delay;
		@(posedge ps_clk_out);
		if (ps_en_out) begin
			delay = 1 + ($unsigned($random(seed)) % 8);
			repeat (delay) @(ps_clk_out);
			@(posedge clk_in);
			#1 ps_done_in = 1'b1;
			@(posedge clk_in);
			#1 ps_done_in = 1'b0;
		end
	end

	always @(posedge clk_in) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout, run still going after %0d cycles", cycle_cnt);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic load_cases(output bit ok);
		int              fd;
		int              n;
		logic [8*96-1:0] line_buf;
		logic [63:0]     kind;
		logic [15:0]     addr;
		logic [15:0]     data;
		logic [15:0]     expv;
		fd = $fopen("tests/ltc2195_cases.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line_buf, fd) != 0) begin
				n = $sscanf(line_buf, "%s %h %h %h", kind, addr, data, expv);
				if (n == 4) begin	// comment lines never give four fields
					case_kind.push_back(kind);
					case_addr.push_back(addr);
					case_data.push_back(data);
					case_exp.push_back(expv);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic issue_command(input cmd_addr_t addr, input cmd_data_t data);
		@(posedge clk_in);
		#1;
		cmd_trig_in = 1'b1;	// single-cycle strobe
		cmd_addr_in = addr;
		cmd_data_in = data;
		@(posedge clk_in);
		#1 cmd_trig_in = 1'b0;
	endtask

	task automatic run_case(input int idx);
		int        seen;
		ps_value_t tgt;
		tgt = case_data[idx][8:0];
		if (case_kind[idx] == "init" || case_kind[idx] == "boot") begin
			// already queued before reset release
		end else if (case_kind[idx] == "spi") begin
			seen = frames_seen;
			chk.push_frame(spi_word_t'(case_exp[idx]));
			issue_command(case_addr[idx], case_data[idx]);
			wait (frames_seen > seen);
		end else if (case_kind[idx] == "phase" || case_kind[idx] == "lock") begin
			seen = moves_seen;
			if (case_kind[idx] == "lock") begin
				@(posedge clk_in);
				#1 ps_locked_in = 1'b0;	// move must stall until relock
			end
			chk.push_move(tgt, case_exp[idx]);
			issue_command(case_addr[idx], case_data[idx]);
			if (case_kind[idx] == "lock") begin
				repeat (LOCK_HOLD) @(posedge clk_in);
				#1 ps_locked_in = 1'b1;
			end
			wait (moves_seen > seen);
		end else if (case_kind[idx] == "other") begin
			issue_command(case_addr[idx], case_data[idx]);
			repeat (QUIET_CYCLES) @(posedge clk_in);
			chk.check_quiet();	// no frame, no pulse
		end else begin
			$display("case %0d has an unknown kind", idx);
			tb_err_cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin : main
		bit ok;
		int n_init;
		int n_boot;
		cmd_trig_in  = 1'b0;
		cmd_addr_in  = '0;
		cmd_data_in  = '0;
		ps_done_in   = 1'b0;
		ps_locked_in = 1'b0;	// out of lock through start-up
		cycle_cnt    = 0;
		cycle_limit  = 0;
		tb_err_cnt   = 0;
		n_init       = 0;
		n_boot       = 0;
		load_cases(ok);
		if (!ok) begin
			$display("could not open the case file");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			cycle_limit = (case_kind.size() + 1) * CASE_CYCLES;
			foreach (case_kind[i]) begin
				if (case_kind[i] == "init") begin
					chk.push_frame(spi_word_t'(case_exp[i]));
					n_init++;
				end else if (case_kind[i] == "boot") begin
					chk.push_move(case_data[i][8:0], case_exp[i]);
					n_boot++;
				end
			end
			wait (rst_in === 1'b0);
			repeat (LOCK_DELAY) @(posedge clk_in);
			#1 ps_locked_in = 1'b1;
			wait (frames_seen == n_init && moves_seen == n_boot);
			foreach (case_kind[i])
				run_case(i);
			repeat (10) @(posedge clk_in);
			chk.check_quiet();
			$display("checks %0d, errors %0d", check_cnt, error_cnt + tb_err_cnt);
			if (error_cnt + tb_err_cnt == 0)
				$display("*** TEST PASSED ***");
			else
				$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

// File: tests/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
//   10 ns clock, reset held for a fixed number of cycles
//////////////////////////////////////////////////////////////////////

module tb_clock_gen #(
	parameter int RESET_CYCLES = 10
) (
	output logic clk_in,
	output logic rst_in
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;	// 100 MHz
	end

	initial begin
		rst_in = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_in);
		#1 rst_in = 1'b0;	// released just after an edge
	end

endmodule
